// File: bench/bus_memory_model.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module bus_memory_model (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    req_i,
   input  logic                    we_i,
   input  dcache_pkg::bus_addr_t   addr_i,
   input  dcache_pkg::qword_t      wdata_i,
   output logic                    ack_o,
   output dcache_pkg::qword_t      rdata_o,
   output logic                    rule_error_o
);

   localparam int QWORD_COUNT = 1 << $bits(dcache_pkg::bus_addr_t);

   dcache_pkg::qword_t mem [QWORD_COUNT];
   integer seed = 32'h377c;
   int wait_left;  // Cycles until the next acknowledge or -1 when idle

   task automatic report_rule_break(input string what);
      $display("Bus rule broken at %0d ns: %s", $time, what);
      rule_error_o = 1'b1;
   endtask

   initial begin
      ack_o <= 1'b0;
      rdata_o <= '0;
      rule_error_o = 1'b0;
      wait_left = -1;
      // Every word holds its own byte address xor 32'h5a5a0000
      for (int q = 0; q < QWORD_COUNT; q++) begin
         for (int k = 0; k < 4; k++) begin
            mem[q][32*k +: 32] = ((q << 4) + (k << 2)) ^ 32'h5a5a0000;
         end
      end
   end

   always @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
         wait_left = -1;
      end else if (ack_o) begin
         ack_o <= 1'b0;  // One-cycle pulse
      end else if (req_i) begin
         if (wait_left < 0) begin
            wait_left = {$random(seed)} % 6;  // 0 to 5 cycles
         end
         if (wait_left == 0) begin
            ack_o <= 1'b1;
            wait_left = -1;
            if (we_i) begin
               mem[addr_i] = wdata_i;
            end else begin
               rdata_o <= mem[addr_i];  // Valid together with the pulse
            end
         end else begin
            wait_left = wait_left - 1;
         end
      end
   end

   a_drop_after_ack: assert property (@(posedge clk_i) disable iff (rst_i)
      req_i && ack_o |=> !req_i)
      else report_rule_break("request still high the cycle after its acknowledge");

   a_no_withdraw: assert property (@(posedge clk_i) disable iff (rst_i)
      req_i && !ack_o |=> req_i)
      else report_rule_break("request dropped before it was acknowledged");

   a_known_request: assert property (@(posedge clk_i) disable iff (rst_i)
      req_i |-> !$isunknown({we_i, addr_i}))
      else report_rule_break("request with an unknown address or write strobe");

endmodule

// File: bench/data_cache_tb.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module data_cache_tb;

   localparam int OP_COUNT = 300;
   localparam int CYCLES_PER_OP = 60;
   localparam int CLK_PERIOD = 100;
   localparam int INDEX_LSB = `DCACHE_OFFSET_WIDTH + 2;
   localparam int TAG_LSB = INDEX_LSB + `DCACHE_INDEX_WIDTH;
   localparam int LINES = 1 << `DCACHE_INDEX_WIDTH;

   logic clk_i = 1'b0;
   logic rst_i;
   logic [31:2] addr_i;
   dcache_pkg::word_t data_i;
   logic en_i;
   dcache_pkg::strobe_t write_en_i;
   dcache_pkg::word_t data_o;
   logic blocking_n_o;
   logic flushing_n_o;
   dcache_pkg::bus_addr_t bus_addr_o;
   dcache_pkg::qword_t bus_data_i;
   logic bus_valid_i;
   logic bus_valid_o;
   logic bus_we_o;
   dcache_pkg::qword_t bus_data_o;
   logic bus_rule_error;

   integer seed = 32'h377c;
   dcache_pkg::word_t shadow [int unsigned];  // Only words that were stored
   logic line_valid [LINES];                  // Expected resident lines
   dcache_pkg::tag_t line_tag [LINES];
   logic line_hit;
   logic read_due = 1'b0;
   dcache_pkg::word_t read_expected;
   logic last_was_store = 1'b0;
   logic [31:0] last_store_addr;

   // Few tags on two indices, so lines keep evicting each other
   dcache_pkg::tag_t tag_pool [4] = '{10'h000, 10'h001, 10'h2a5, 10'h3ff};
   dcache_pkg::index_t index_pool [2] = '{4'h0, 4'h9};

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   data_cache data_cache_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .addr_i(addr_i), .data_i(data_i), .en_i(en_i), .write_en_i(write_en_i),
      .data_o(data_o), .blocking_n_o(blocking_n_o), .flushing_n_o(flushing_n_o),
      .bus_addr_o(bus_addr_o), .bus_data_i(bus_data_i), .bus_valid_i(bus_valid_i),
      .bus_valid_o(bus_valid_o), .bus_we_o(bus_we_o), .bus_data_o(bus_data_o)
   );

   bus_memory_model memory_model_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .req_i(bus_valid_o), .we_i(bus_we_o), .addr_i(bus_addr_o), .wdata_i(bus_data_o),
      .ack_o(bus_valid_i), .rdata_o(bus_data_i), .rule_error_o(bus_rule_error)
   );

   assign line_hit = line_valid[addr_i[TAG_LSB-1:INDEX_LSB]]
      && (line_tag[addr_i[TAG_LSB-1:INDEX_LSB]] == addr_i[`DCACHE_BUS_ADDR_WIDTH-1:TAG_LSB]);

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   function automatic dcache_pkg::word_t shadow_word(input int unsigned word_addr);
      if (shadow.exists(word_addr)) begin
         return shadow[word_addr];
      end
      return (word_addr << 2) ^ 32'h5a5a0000;  // Memory contents before any store
   endfunction

   task automatic pick_op(output logic [31:0] op_addr, output dcache_pkg::word_t op_data,
                          output dcache_pkg::strobe_t op_strobe);
      op_data = $random(seed);
      op_strobe = '0;
      if (last_was_store && (({$random(seed)} % 3) == 0)) begin
         op_addr = last_store_addr;  // Read back the word just stored
      end else begin
         op_addr = $random(seed);    // Bits above the bus space stay random
         op_addr[TAG_LSB +: `DCACHE_TAG_WIDTH] = tag_pool[{$random(seed)} % 4];
         op_addr[INDEX_LSB +: `DCACHE_INDEX_WIDTH] = index_pool[{$random(seed)} % 2];
         if (({$random(seed)} % 5) < 2) begin
            op_strobe = 4'($random(seed));
            if (op_strobe == '0) begin
               op_strobe = 4'hf;
            end
         end
      end
   endtask

   // Bookkeeping at the edge where the request is accepted
   task automatic record_op(input logic [31:0] op_addr, input dcache_pkg::word_t op_data,
                            input dcache_pkg::strobe_t op_strobe);
      int unsigned word_addr;
      dcache_pkg::word_t merged;
      dcache_pkg::index_t index;
      word_addr = op_addr[`DCACHE_BUS_ADDR_WIDTH-1:2];
      index = op_addr[INDEX_LSB +: `DCACHE_INDEX_WIDTH];
      line_valid[index] = 1'b1;
      line_tag[index] = op_addr[TAG_LSB +: `DCACHE_TAG_WIDTH];
      if (op_strobe == '0) begin
         read_expected = shadow_word(word_addr);
         read_due = 1'b1;
      end else begin
         merged = shadow_word(word_addr);
         for (int b = 0; b < 4; b++) begin
            if (op_strobe[b]) begin
               merged[8*b +: 8] = op_data[8*b +: 8];
            end
         end
         shadow[word_addr] = merged;
      end
      last_was_store = (op_strobe != '0);
      last_store_addr = op_addr;
   endtask

   // data_o holds the result from the first falling edge after acceptance
   task automatic check_read();
      if (read_due) begin
         read_due = 1'b0;
         assert (data_o === read_expected)
            else stop_with_failure($sformatf("Mismatch at %0d ns: data_o is %h, expected %h",
                                             $time, data_o, read_expected));
      end
   endtask

   initial begin
      logic [31:0] op_addr;
      dcache_pkg::word_t op_data;
      dcache_pkg::strobe_t op_strobe;
      rst_i <= 1'b1;
      en_i <= 1'b0;
      addr_i <= '0;
      data_i <= '0;
      write_en_i <= '0;
      for (int i = 0; i < LINES; i++) begin
         line_valid[i] = 1'b0;
      end
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;
      @(negedge clk_i);
      assert (!bus_valid_o && !bus_we_o && flushing_n_o)
         else stop_with_failure("Bus request or refill level active after reset");
      @(posedge clk_i);
      for (int n = 0; n < OP_COUNT; n++) begin
         pick_op(op_addr, op_data, op_strobe);
         en_i <= 1'b1;
         addr_i <= op_addr[31:2];
         data_i <= op_data;
         write_en_i <= op_strobe;
         do begin
            @(negedge clk_i);
            check_read();
         end while (!blocking_n_o);
         @(posedge clk_i);  // Accepted here
         record_op(op_addr, op_data, op_strobe);
      end
      en_i <= 1'b0;
      @(negedge clk_i);
      check_read();
      repeat (2) @(posedge clk_i);
      if (bus_rule_error) begin
         stop_with_failure("Memory model reported a broken bus rule at the end of the run");
      end else begin
         $display("*** TEST PASSED ***");
         $finish;
      end
   end

   // Evicted dirty qwords must match the core's view of memory
   always @(negedge clk_i) begin
      dcache_pkg::word_t expected;
      if (!rst_i && bus_valid_o && bus_we_o && bus_valid_i) begin
         for (int k = 0; k < 4; k++) begin
            expected = shadow_word({bus_addr_o, 2'(k)});
            assert (bus_data_o[32*k +: 32] === expected)
               else stop_with_failure($sformatf(
                  "Mismatch at %0d ns: bus_data_o word %0d at qword %h is %h, expected %h",
                  $time, k, bus_addr_o, bus_data_o[32*k +: 32], expected));
         end
      end
   end

   a_bus_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      bus_valid_o && !bus_valid_i |=> bus_valid_o && $stable(bus_addr_o)
         && $stable(bus_we_o) && $stable(bus_data_o))
      else stop_with_failure("Bus request changed before it was acknowledged");

   a_hit_not_blocked: assert property (@(negedge clk_i) disable iff (rst_i)
      en_i && flushing_n_o && line_hit |-> blocking_n_o)
      else stop_with_failure("Access to a resident line was stalled");

   // Bus traffic only inside a refill
   a_refill_level: assert property (@(posedge clk_i) disable iff (rst_i)
      bus_valid_o |-> !flushing_n_o)
      else stop_with_failure("Bus request issued while flushing_n_o was high");

   a_refill_end: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(flushing_n_o) |-> blocking_n_o)
      else stop_with_failure("Stall still active in the cycle the refill ended");

   a_bus_rules: assert property (@(posedge clk_i) disable iff (rst_i)
      !bus_rule_error)
      else stop_with_failure("Memory model reported a broken bus rule");

   initial begin
      #(OP_COUNT * CYCLES_PER_OP * CLK_PERIOD);
      stop_with_failure("Watchdog expired before all operations completed");
   end

endmodule

// File: flist.f
+incdir+include
logic/dcache_pkg.sv
logic/dcache_request_stage.sv
logic/dcache_miss_engine.sv
logic/dcache_line_store.sv
logic/dcache_read_port.sv
logic/data_cache.sv
bench/bus_memory_model.sv
bench/data_cache_tb.sv

// File: include/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Cache geometry
`define DCACHE_INDEX_WIDTH 4
`define DCACHE_OFFSET_WIDTH 4
`define DCACHE_BUS_ADDR_WIDTH 20

// Derived sizes
`define DCACHE_QSEL_WIDTH (`DCACHE_OFFSET_WIDTH - 2)
`define DCACHE_LINE_COUNT (1 << `DCACHE_INDEX_WIDTH)
`define DCACHE_WORDS_PER_LINE (1 << `DCACHE_OFFSET_WIDTH)
`define DCACHE_QWORDS_PER_LINE (1 << `DCACHE_QSEL_WIDTH)

// Byte address = tag | index | word offset | 2 byte bits
`define DCACHE_TAG_WIDTH \
   (`DCACHE_BUS_ADDR_WIDTH - `DCACHE_INDEX_WIDTH - `DCACHE_OFFSET_WIDTH - 2)

`endif

// File: logic/data_cache.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module data_cache (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic [31:2]             addr_i,
   input  dcache_pkg::word_t       data_i,
   input  logic                    en_i,
   input  dcache_pkg::strobe_t     write_en_i,
   output dcache_pkg::word_t       data_o,
   output logic                    blocking_n_o,
   output logic                    flushing_n_o,
   output dcache_pkg::bus_addr_t   bus_addr_o,
   input  dcache_pkg::qword_t      bus_data_i,
   input  logic                    bus_valid_i,
   output logic                    bus_valid_o,
   output logic                    bus_we_o,
   output dcache_pkg::qword_t      bus_data_o
);

   dcache_pkg::tag_t cur_tag;
   dcache_pkg::index_t cur_index;
   dcache_pkg::offset_t cur_offset;
   dcache_pkg::tag_t pend_tag;
   dcache_pkg::index_t pend_index;
   dcache_pkg::offset_t pend_offset;
   dcache_pkg::word_t pend_data;
   dcache_pkg::strobe_t pend_strobe;
   logic pend_valid;
   logic stall_n;
   logic refill_we;
   dcache_pkg::index_t refill_index;
   dcache_pkg::qsel_t refill_qsel;
   dcache_pkg::qsel_t flush_rd_qsel;
   logic clean;
   dcache_pkg::word_t rd_word;
   dcache_pkg::qword_t wb_qword;
   logic [`DCACHE_QWORDS_PER_LINE-1:0] dirty_bits;

   assign blocking_n_o = stall_n;

   dcache_request_stage request_stage_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .addr_i(addr_i), .data_i(data_i), .en_i(en_i), .write_en_i(write_en_i),
      .stall_n_i(stall_n),
      .cur_tag_o(cur_tag), .cur_index_o(cur_index), .cur_offset_o(cur_offset),
      .pend_index_o(pend_index), .pend_offset_o(pend_offset), .pend_tag_o(pend_tag),
      .pend_data_o(pend_data), .pend_strobe_o(pend_strobe), .pend_valid_o(pend_valid)
   );

   dcache_miss_engine miss_engine_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .cur_tag_i(cur_tag), .cur_index_i(cur_index), .en_i(en_i),
      .pend_tag_i(pend_tag), .pend_index_i(pend_index), .pend_valid_i(pend_valid),
      .dirty_bits_i(dirty_bits), .wb_qword_i(wb_qword),
      .bus_data_i(bus_data_i), .bus_valid_i(bus_valid_i),
      .stall_n_o(stall_n), .flushing_n_o(flushing_n_o),
      .refill_we_o(refill_we), .refill_index_o(refill_index), .refill_qsel_o(refill_qsel),
      .flush_rd_qsel_o(flush_rd_qsel), .clean_o(clean),
      .bus_addr_o(bus_addr_o), .bus_valid_o(bus_valid_o), .bus_we_o(bus_we_o),
      .bus_data_o(bus_data_o)
   );

   // Pending store only exists after a hit, the line is still resident when it lands
   dcache_line_store line_store_i (
      .clk_i(clk_i), .rst_i(rst_i),
      .wr_index_i(pend_index), .wr_offset_i(pend_offset), .wr_data_i(pend_data),
      .wr_strobe_i(pend_strobe), .wr_en_i(pend_valid),
      .rd_index_i(cur_index), .rd_offset_i(cur_offset),
      .refill_we_i(refill_we), .refill_index_i(refill_index), .refill_qsel_i(refill_qsel),
      .refill_data_i(bus_data_i), .flush_rd_qsel_i(flush_rd_qsel), .clean_i(clean),
      .rd_word_o(rd_word), .wb_qword_o(wb_qword), .dirty_bits_o(dirty_bits)
   );

   dcache_read_port read_port_i (
      .clk_i(clk_i),
      .rd_word_i(rd_word), .cur_index_i(cur_index), .cur_offset_i(cur_offset),
      .pend_index_i(pend_index), .pend_offset_i(pend_offset), .pend_data_i(pend_data),
      .pend_strobe_i(pend_strobe), .pend_valid_i(pend_valid),
      .en_i(en_i), .stall_n_i(stall_n),
      .data_o(data_o)
   );

endmodule

// File: logic/dcache_line_store.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_line_store (
   input  logic                                 clk_i,
   input  logic                                 rst_i,
   input  dcache_pkg::index_t                   wr_index_i,
   input  dcache_pkg::offset_t                  wr_offset_i,
   input  dcache_pkg::word_t                    wr_data_i,
   input  dcache_pkg::strobe_t                  wr_strobe_i,
   input  logic                                 wr_en_i,
   input  dcache_pkg::index_t                   rd_index_i,
   input  dcache_pkg::offset_t                  rd_offset_i,
   input  logic                                 refill_we_i,
   input  dcache_pkg::index_t                   refill_index_i,
   input  dcache_pkg::qsel_t                    refill_qsel_i,
   input  dcache_pkg::qword_t                   refill_data_i,
   input  dcache_pkg::qsel_t                    flush_rd_qsel_i,
   input  logic                                 clean_i,
   output dcache_pkg::word_t                    rd_word_o,
   output dcache_pkg::qword_t                   wb_qword_o,
   output logic [`DCACHE_QWORDS_PER_LINE-1:0]   dirty_bits_o
);

   dcache_pkg::word_t mem_q [`DCACHE_LINE_COUNT][`DCACHE_WORDS_PER_LINE];
   logic [`DCACHE_QWORDS_PER_LINE-1:0] dirty_q [`DCACHE_LINE_COUNT];
   dcache_pkg::qsel_t wr_qsel;
   logic byte_write;

   assign wr_qsel = wr_offset_i[`DCACHE_OFFSET_WIDTH-1:2];
   assign byte_write = wr_en_i && (wr_strobe_i != '0);

   always_ff @(posedge clk_i) begin
      for (int b = 0; b < 4; b++) begin
         if (wr_en_i && wr_strobe_i[b]) begin
            mem_q[wr_index_i][wr_offset_i][8*b +: 8] <= wr_data_i[8*b +: 8];
         end
      end
      // Whole qword from the bus, word 0 in the low bits
      if (refill_we_i) begin
         for (int k = 0; k < 4; k++) begin
            mem_q[refill_index_i][{refill_qsel_i, 2'(k)}] <= refill_data_i[32*k +: 32];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < `DCACHE_LINE_COUNT; i++) begin
            dirty_q[i] <= '0;
         end
      end else begin
         if (refill_we_i) begin
            dirty_q[refill_index_i][refill_qsel_i] <= 1'b0;
         end
         if (clean_i) begin
            dirty_q[refill_index_i][flush_rd_qsel_i] <= 1'b0;  // Writeback acknowledged
         end
         if (byte_write) begin
            dirty_q[wr_index_i][wr_qsel] <= 1'b1;
         end
      end
   end

   assign rd_word_o = mem_q[rd_index_i][rd_offset_i];
   assign wb_qword_o = {mem_q[refill_index_i][{flush_rd_qsel_i, 2'd3}],
                        mem_q[refill_index_i][{flush_rd_qsel_i, 2'd2}],
                        mem_q[refill_index_i][{flush_rd_qsel_i, 2'd1}],
                        mem_q[refill_index_i][{flush_rd_qsel_i, 2'd0}]};
   assign dirty_bits_o = dirty_q[refill_index_i];

   // Stores are held off while a line is refilled
   a_no_write_clash: assert property (@(posedge clk_i) disable iff (rst_i)
      byte_write && refill_we_i |-> (wr_index_i != refill_index_i) || (wr_qsel != refill_qsel_i));

endmodule

// File: logic/dcache_miss_engine.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_miss_engine (
   input  logic                                 clk_i,
   input  logic                                 rst_i,
   input  dcache_pkg::tag_t                     cur_tag_i,
   input  dcache_pkg::index_t                   cur_index_i,
   input  logic                                 en_i,
   input  dcache_pkg::tag_t                     pend_tag_i,
   input  dcache_pkg::index_t                   pend_index_i,
   input  logic                                 pend_valid_i,
   input  logic [`DCACHE_QWORDS_PER_LINE-1:0]   dirty_bits_i,
   input  dcache_pkg::qword_t                   wb_qword_i,
   input  dcache_pkg::qword_t                   bus_data_i,
   input  logic                                 bus_valid_i,
   output logic                                 stall_n_o,
   output logic                                 flushing_n_o,
   output logic                                 refill_we_o,
   output dcache_pkg::index_t                   refill_index_o,
   output dcache_pkg::qsel_t                    refill_qsel_o,
   output dcache_pkg::qsel_t                    flush_rd_qsel_o,
   output logic                                 clean_o,
   output dcache_pkg::bus_addr_t                bus_addr_o,
   output logic                                 bus_valid_o,
   output logic                                 bus_we_o,
   output dcache_pkg::qword_t                   bus_data_o
);

   dcache_pkg::miss_state_t state_q;
   dcache_pkg::tag_t tag_q [`DCACHE_LINE_COUNT];
   logic [`DCACHE_LINE_COUNT-1:0] valid_q;
   dcache_pkg::tag_t old_tag_q;     // Evicted tag for writeback addresses
   dcache_pkg::index_t line_index_q;
   dcache_pkg::qsel_t qsel_q;
   dcache_pkg::qsel_t qsel_inc;
   logic qsel_last;
   logic flushing_n_q;
   logic cur_hit;
   logic pend_hit;
   logic wb_needed;

   assign cur_hit = valid_q[cur_index_i] && (tag_q[cur_index_i] == cur_tag_i);
   assign pend_hit = valid_q[pend_index_i] && (tag_q[pend_index_i] == pend_tag_i);

   assign stall_n_o = (!en_i || cur_hit)
                    && (state_q == dcache_pkg::IDLE)
                    && (!pend_valid_i || pend_hit);
   assign flushing_n_o = flushing_n_q;

   // Qword counter, carry marks the last qword of the line
   assign {qsel_last, qsel_inc} = {1'b0, qsel_q} + 1'b1;

   // NEXT looks ahead at the qword about to be handled
   assign flush_rd_qsel_o = (state_q == dcache_pkg::NEXT) ? qsel_inc : qsel_q;
   assign wb_needed = dirty_bits_i[flush_rd_qsel_o];

   assign refill_index_o = line_index_q;
   assign refill_qsel_o = qsel_q;
   assign refill_we_o = (state_q == dcache_pkg::REFILL_WAIT) && bus_valid_i;
   assign clean_o = (state_q == dcache_pkg::WRITEBACK) && bus_valid_i;

   // New tag is already installed, old one only for writes
   assign bus_addr_o = {bus_we_o ? old_tag_q : tag_q[line_index_q], line_index_q, qsel_q};

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= dcache_pkg::IDLE;
         valid_q <= '0;
         flushing_n_q <= 1'b1;
         bus_valid_o <= 1'b0;
         bus_we_o <= 1'b0;
      end else begin
         case (state_q)
            dcache_pkg::IDLE: begin
               if (en_i && !cur_hit) begin
                  line_index_q <= cur_index_i;
                  qsel_q <= '0;
                  state_q <= dcache_pkg::START;
               end
            end
            dcache_pkg::START: begin
               old_tag_q <= tag_q[line_index_q];
               tag_q[line_index_q] <= cur_tag_i;
               valid_q[line_index_q] <= 1'b1;
               flushing_n_q <= 1'b0;
               // Launch qword 0, writeback first if dirty
               bus_valid_o <= 1'b1;
               bus_we_o <= wb_needed;
               bus_data_o <= wb_qword_i;
               state_q <= wb_needed ? dcache_pkg::WRITEBACK : dcache_pkg::REFILL_WAIT;
            end
            dcache_pkg::WRITEBACK: begin
               if (bus_valid_i) begin
                  bus_valid_o <= 1'b0;  // Low for one cycle before the read
                  bus_we_o <= 1'b0;
                  state_q <= dcache_pkg::REFILL_REQ;
               end
            end
            dcache_pkg::REFILL_REQ: begin
               bus_valid_o <= 1'b1;
               state_q <= dcache_pkg::REFILL_WAIT;
            end
            dcache_pkg::REFILL_WAIT: begin
               if (bus_valid_i) begin
                  bus_valid_o <= 1'b0;
                  state_q <= dcache_pkg::NEXT;
               end
            end
            dcache_pkg::NEXT: begin
               if (qsel_last) begin
                  flushing_n_q <= 1'b1;
                  state_q <= dcache_pkg::IDLE;
               end else begin
                  qsel_q <= qsel_inc;
                  bus_valid_o <= 1'b1;
                  bus_we_o <= wb_needed;
                  bus_data_o <= wb_qword_i;
                  state_q <= wb_needed ? dcache_pkg::WRITEBACK : dcache_pkg::REFILL_WAIT;
               end
            end
            default: state_q <= dcache_pkg::IDLE;
         endcase
      end
   end

   // Request held steady until the memory acknowledges it
   a_bus_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      bus_valid_o && !bus_valid_i |=> bus_valid_o && $stable(bus_addr_o)
         && $stable(bus_we_o) && (!bus_we_o || $stable(bus_data_o)));

   // Memory answers a read with defined data
   a_refill_known: assert property (@(posedge clk_i) disable iff (rst_i)
      refill_we_o |-> !$isunknown(bus_data_i));

endmodule

// File: logic/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

   typedef logic [31:0] word_t;    // Core data word
   typedef logic [3:0] strobe_t;   // Byte enables
   typedef logic [127:0] qword_t;  // Bus beat

   typedef logic [`DCACHE_TAG_WIDTH-1:0] tag_t;
   typedef logic [`DCACHE_INDEX_WIDTH-1:0] index_t;
   typedef logic [`DCACHE_OFFSET_WIDTH-1:0] offset_t;  // Word within the line
   typedef logic [`DCACHE_QSEL_WIDTH-1:0] qsel_t;      // Qword within the line

   // Qword address on the bus
   typedef logic [`DCACHE_TAG_WIDTH + `DCACHE_INDEX_WIDTH + `DCACHE_QSEL_WIDTH - 1:0]
      bus_addr_t;

   // Miss handling, one pass of WRITEBACK/REFILL per qword
   typedef enum logic [2:0] {
      IDLE,
      START,
      WRITEBACK,
      REFILL_REQ,
      REFILL_WAIT,
      NEXT
   } miss_state_t;

endpackage

// File: logic/dcache_read_port.sv
`timescale 1ns/1ps

module dcache_read_port (
   input  logic                  clk_i,
   input  dcache_pkg::word_t     rd_word_i,
   input  dcache_pkg::index_t    cur_index_i,
   input  dcache_pkg::offset_t   cur_offset_i,
   input  dcache_pkg::index_t    pend_index_i,
   input  dcache_pkg::offset_t   pend_offset_i,
   input  dcache_pkg::word_t     pend_data_i,
   input  dcache_pkg::strobe_t   pend_strobe_i,
   input  logic                  pend_valid_i,
   input  logic                  en_i,
   input  logic                  stall_n_i,
   output dcache_pkg::word_t     data_o
);

   logic forward;
   dcache_pkg::word_t merged;

   // Same word as the store still on its way into the array
   assign forward = pend_valid_i
                 && (pend_index_i == cur_index_i)
                 && (pend_offset_i == cur_offset_i);

   always_comb begin
      merged = rd_word_i;
      for (int b = 0; b < 4; b++) begin
         if (forward && pend_strobe_i[b]) begin
            merged[8*b +: 8] = pend_data_i[8*b +: 8];
         end
      end
   end

   // Updates only on an accepted request
   always_ff @(posedge clk_i) begin
      if (en_i && stall_n_i) begin
         data_o <= merged;
      end
   end

endmodule

// File: logic/dcache_request_stage.sv
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_request_stage (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic [31:2]             addr_i,
   input  dcache_pkg::word_t       data_i,
   input  logic                    en_i,
   input  dcache_pkg::strobe_t     write_en_i,
   input  logic                    stall_n_i,
   output dcache_pkg::tag_t        cur_tag_o,
   output dcache_pkg::index_t      cur_index_o,
   output dcache_pkg::offset_t     cur_offset_o,
   output dcache_pkg::index_t      pend_index_o,
   output dcache_pkg::offset_t     pend_offset_o,
   output dcache_pkg::tag_t        pend_tag_o,
   output dcache_pkg::word_t       pend_data_o,
   output dcache_pkg::strobe_t     pend_strobe_o,
   output logic                    pend_valid_o
);

   localparam int INDEX_LSB = `DCACHE_OFFSET_WIDTH + 2;
   localparam int TAG_LSB = INDEX_LSB + `DCACHE_INDEX_WIDTH;
   localparam int TAG_MSB = `DCACHE_BUS_ADDR_WIDTH - 1;  // Upper address bits ignored

   logic accept_store;

   assign cur_offset_o = addr_i[INDEX_LSB-1:2];
   assign cur_index_o = addr_i[TAG_LSB-1:INDEX_LSB];
   assign cur_tag_o = addr_i[TAG_MSB:TAG_LSB];

   assign accept_store = en_i && stall_n_i && (write_en_i != '0);

   // Delayed store lands one cycle after it is accepted
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pend_valid_o <= 1'b0;
      end else begin
         pend_valid_o <= accept_store;  // Reads and idle cycles drop it
      end
   end

   // Store fields hold while stalled
   always_ff @(posedge clk_i) begin
      if (accept_store) begin
         pend_tag_o <= cur_tag_o;
         pend_index_o <= cur_index_o;
         pend_offset_o <= cur_offset_o;
         pend_data_o <= data_i;
         pend_strobe_o <= write_en_i;
      end
   end

   // Core must hold its request while the cache stalls it
   a_core_holds: assert property (@(posedge clk_i) disable iff (rst_i)
      en_i && !stall_n_i |=> $stable(addr_i) && $stable(write_en_i));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator and runs it
# The exit status is the simulation's own

cd "$(dirname "$0")" &&
   verilator --binary --timing --assert -Wno-fatal \
      -f flist.f --top-module data_cache_tb -o data_cache_sim &&
   ./obj_dir/data_cache_sim ||
   { echo "Simulation failed" >&2; exit 1; }
